//--- project.f
icache_pkg.sv
icache_ram.sv
icache_plru.sv
icache_refill.sv
icache_lookup.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv

//--- tb_icache.sv
`timescale 1ns/10ps

module tb_icache
    import icache_pkg::*;
;

    localparam int IDX_W    = 7;
    localparam int OFF_W    = 5;
    localparam int TAG_W    = ADDR_W - IDX_W - OFF_W;
    localparam int SET_NUM  = 1 << IDX_W;
    localparam int BANK_NUM = 1 << (OFF_W - 2);
    localparam int N_DIR    = 10;
    localparam int N_RAND   = 300;
    localparam int N_TOTAL  = N_DIR + N_RAND;
    localparam int WATCHDOG_CYCLES = 400 * N_TOTAL;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] pc_next, pc;
    logic              inst_en, fetch_stall;
    logic [WORD_W-1:0] inst_rdata;
    logic              stall;
    axi_ar_t           ar;
    logic              arvalid, arready;
    axi_r_t            r;
    logic              rvalid, rready;

    // reference model of tags and tree bits per set
    logic [TAG_W-1:0] m_tag [SET_NUM][WAY_NUM];
    bit               m_valid [SET_NUM][WAY_NUM];
    bit               m_root [SET_NUM];  // 1 means victim in ways 2/3
    bit               m_lo [SET_NUM];    // 1 means way 1 over way 0
    bit               m_hi [SET_NUM];    // 1 means way 3 over way 2

    logic [ADDR_W-1:0] pcs [$];
    int                ptr;
    int                fetch_count;
    int                ar_seen;  // ar handshakes for the current pc
    bit                cur_miss, in_burst, advance, started;
    int                set_pool [3] = '{3, 9, 100};

    icache_top #(.INDEX_WIDTH(IDX_W), .OFFSET_WIDTH(OFF_W)) UUT (
        .clk, .rst, .pc_next, .pc, .inst_en, .fetch_stall, .inst_rdata, .stall,
        .ar, .arvalid, .arready, .r, .rvalid, .rready
    );

    tb_axi_mem u_mem (
        .clk, .rst, .ar, .arvalid, .arready, .r, .rvalid, .rready
    );

    always #2 clk = ~clk;

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
        return {2'b00, a[ADDR_W-1:2]} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    endfunction

    function automatic logic [ADDR_W-1:0] make_pc(input int tag, input int set, input int word);
        return ADDR_W'(tag) << (IDX_W + OFF_W) | ADDR_W'(set) << OFF_W | ADDR_W'(word) << 2;
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    // predict hit or miss, then touch or fill the way
    task automatic model_access(input logic [ADDR_W-1:0] a, output bit miss);
        int               idx;
        int               way;
        logic [TAG_W-1:0] tag;
        idx = a[OFF_W +: IDX_W];
        tag = a[ADDR_W-1 -: TAG_W];
        way = -1;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) way = w;
        end
        miss = (way < 0);
        if (miss) begin
            way = m_root[idx] ? 2 + int'(m_hi[idx]) : int'(m_lo[idx]);
            m_tag[idx][way]   = tag;
            m_valid[idx][way] = 1'b1;
        end
        m_root[idx] = (way < 2);  // away from the touched half
        if (way < 2) m_lo[idx] = (way == 0);
        else         m_hi[idx] = (way == 2);
    endtask

    initial begin
        clk = 1'b0;
        void'($urandom(32'hda70384d));
        rst         = 1'b1;
        inst_en     = 1'b0;
        fetch_stall = 1'b0;
        // five lines into set 9, then the kept four and the evicted one
        for (int t = 1; t <= 5; t++) pcs.push_back(make_pc('h40 + t, 9, 0));
        for (int t = 2; t <= 5; t++) pcs.push_back(make_pc('h40 + t, 9, 6));
        pcs.push_back(make_pc('h41, 9, 6));
        for (int i = 0; i < N_RAND; i++) begin
            pcs.push_back(make_pc('h40 + $urandom_range(6, 1), set_pool[$urandom_range(2)],
                                  $urandom_range(BANK_NUM - 1)));
        end
        pc      = pcs[0];
        pc_next = pcs[1];  // pc_next equals the first pc's successor
        ptr     = 2;
        model_access(pc, cur_miss);
        repeat (8) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        @(posedge clk);
        assert (!stall && !arvalid && !rready)
            else report_error("stall, arvalid or rready high after reset");
        started = 1'b1;
        wait (fetch_count == N_TOTAL);
        $display("Regression passed");
        $finish;
    end

    // fetch stage advances on the edge after an accepted fetch
    always @(negedge clk) begin
        if (started) begin
            inst_en = 1'b1;
            if (advance) begin
                pc = pc_next;
                if (ptr < N_TOTAL) begin
                    pc_next = pcs[ptr];
                    ptr++;
                end
                model_access(pc, cur_miss);
                ar_seen = 0;
            end
            fetch_stall = ($urandom_range(3) == 0);
        end
    end

    // all checks use values settled before the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (in_burst || arvalid) begin
                assert (stall) else report_error("stall low while a refill is open");
            end
            // rready only from the accepted AR up to the last beat
            assert (rready == in_burst)
                else report_error($sformatf("rready %0b, expected %0b", rready, in_burst));
            if (arvalid && arready) begin
                assert (cur_miss && ar_seen == 0)
                    else report_error($sformatf("unexpected AR for pc %h", pc));
                assert (ar.addr == line_of(pc) && ar.len == 8'(BANK_NUM - 1))
                    else report_error($sformatf("AR addr %h len %0d, expected %h len %0d",
                                                ar.addr, ar.len, line_of(pc), BANK_NUM - 1));
                ar_seen++;
                in_burst = 1'b1;
            end
            if (rvalid && rready && r.last) begin
                in_burst = 1'b0;  // refill closed by the last beat
            end
            advance = 1'b0;
            if (!stall && inst_en) begin
                assert (inst_rdata == expected_word(pc))
                    else report_error($sformatf("inst_rdata %h for pc %h, expected %h",
                                                inst_rdata, pc, expected_word(pc)));
                if (!fetch_stall) begin
                    assert (ar_seen == int'(cur_miss))
                        else report_error($sformatf("pc %h saw %0d AR, model miss %0b",
                                                    pc, ar_seen, cur_miss));
                    fetch_count++;
                    advance = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the run hung before all fetches were accepted");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/10ps

module tb_axi_mem
    import icache_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);

    logic [ADDR_W-1:0] base;   // line address of the open burst
    logic [7:0]        len;
    logic [7:0]        beat;   // index of the beat on the bus
    bit                busy;   // burst accepted, beats still owed
    bit                taken;  // r beat accepted at the last rising edge

    // memory contents, word address xor a fixed pattern
    function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] a);
        return {2'b00, a[ADDR_W-1:2]} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
    end

    // handshakes are sampled on the rising edge
    always @(posedge clk) begin
        taken = 1'b0;
        if (rst) begin
            busy = 1'b0;
            beat = '0;
        end else begin
            if (arvalid && arready && !busy) begin
                base = ar.addr;
                len  = ar.len;
                beat = '0;
                busy = 1'b1;
            end
            if (rvalid && rready) begin
                taken = 1'b1;
                if (beat == len) begin
                    busy = 1'b0;  // last beat gone
                end else begin
                    beat = beat + 1'b1;
                end
            end
        end
    end

    // outputs change on the falling edge only
    always @(negedge clk) begin
        arready = !rst && !busy && ($urandom_range(2) != 0);
        if (taken) begin
            rvalid = 1'b0;
        end
        // a raised rvalid keeps its payload until accepted
        if (busy && !rvalid) begin
            rvalid = ($urandom_range(2) != 0);  // random gaps between beats
            r.data = word_at(base + 4 * beat);
            r.last = (beat == len);
        end
    end

endmodule

//--- icache_top.sv
`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_WIDTH  = 7,
    parameter int OFFSET_WIDTH = 5
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] pc_next,
    input  logic [ADDR_W-1:0] pc,
    input  logic              inst_en,
    input  logic              fetch_stall,
    output logic [WORD_W-1:0] inst_rdata,
    output logic              stall,
    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rready
);

    localparam int TAG_W    = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int BANK_W   = OFFSET_WIDTH - BYTE_OFF_W;
    localparam int BANK_NUM = 1 << BANK_W;

    logic [WAY_NUM-1:0][TAG_W:0]                  tag_rd;
    logic [WAY_NUM-1:0][BANK_NUM-1:0][WORD_W-1:0] word_rd;
    logic [WAY_W-1:0]       victim_way, touch_way;
    logic [WORD_W-1:0]      saved_word, fill_data;
    logic                   fill_done, miss_req, touch;
    logic [ADDR_W-1:0]      line_addr;
    logic [BANK_W-1:0]      word_off;
    logic [BANK_NUM-1:0]    bank_we;
    logic [WAY_NUM-1:0]     way_mask;
    logic [INDEX_WIDTH-1:0] pc_index, rd_index;
    logic [TAG_W:0]         tag_wdata;
    logic                   first_cycle;

    // pc_next is not meaningful on the first edge out of reset
    always_ff @(posedge clk) begin
        if (rst) first_cycle <= 1'b1;
        else     first_cycle <= 1'b0;
    end

    assign pc_index  = pc[OFFSET_WIDTH +: INDEX_WIDTH];
    assign rd_index  = first_cycle ? pc_index : pc_next[OFFSET_WIDTH +: INDEX_WIDTH];
    assign way_mask  = WAY_NUM'(1) << touch_way;  // fill way one-hot
    assign tag_wdata = {line_addr[ADDR_W-1 -: TAG_W], 1'b1};

    icache_lookup #(.INDEX_WIDTH(INDEX_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH)) u_lookup (
        .clk, .rst, .pc, .inst_en, .fetch_stall, .tag_rd, .word_rd, .victim_way,
        .saved_word, .fill_done, .inst_rdata, .stall, .miss_req, .line_addr,
        .word_off, .touch, .touch_way, .hit_way()
    );

    icache_plru #(.INDEX_WIDTH(INDEX_WIDTH)) u_plru (
        .clk, .rst, .index(pc_index), .touch, .touch_way, .victim_way
    );

    icache_refill #(.OFFSET_WIDTH(OFFSET_WIDTH)) u_refill (
        .clk, .rst, .miss_req, .line_addr, .word_off, .ar, .arvalid, .arready,
        .r, .rvalid, .rready, .bank_we, .fill_data, .fill_done, .saved_word
    );

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        // tag written once, on the last beat
        icache_ram #(.WIDTH(TAG_W + 1), .DEPTH_LOG2(INDEX_WIDTH)) u_tag (
            .clk, .we(fill_done & way_mask[w]), .waddr(pc_index), .wdata(tag_wdata),
            .re(~fetch_stall), .raddr(rd_index), .rdata(tag_rd[w])
        );
        for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
            icache_ram #(.WIDTH(WORD_W), .DEPTH_LOG2(INDEX_WIDTH)) u_data (
                .clk, .we(bank_we[b] & way_mask[w]), .waddr(pc_index),
                .wdata(fill_data), .re(~fetch_stall), .raddr(rd_index),
                .rdata(word_rd[w][b])
            );
        end
    end

endmodule

//--- icache_lookup.sv
`timescale 1ns/10ps

module icache_lookup
    import icache_pkg::*;
#(
    parameter  int INDEX_WIDTH  = 7,
    parameter  int OFFSET_WIDTH = 5,
    localparam int TAG_W        = ADDR_W - INDEX_WIDTH - OFFSET_WIDTH,
    localparam int BANK_W       = OFFSET_WIDTH - BYTE_OFF_W,
    localparam int BANK_NUM     = 1 << BANK_W
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [ADDR_W-1:0]                       pc,
    input  logic                                    inst_en,
    input  logic                                    fetch_stall,
    input  logic [WAY_NUM-1:0][TAG_W:0]             tag_rd,
    input  logic [WAY_NUM-1:0][BANK_NUM-1:0][WORD_W-1:0] word_rd,
    input  logic [WAY_W-1:0]                        victim_way,
    input  logic [WORD_W-1:0]                       saved_word,
    input  logic                                    fill_done,
    output logic [WORD_W-1:0]                       inst_rdata,
    output logic                                    stall,
    output logic                                    miss_req,
    output logic [ADDR_W-1:0]                       line_addr,
    output logic [BANK_W-1:0]                       word_off,
    output logic                                    touch,
    output logic [WAY_W-1:0]                        touch_way,
    output logic [WAY_W-1:0]                        hit_way
);

    localparam int SET_NUM = 1 << INDEX_WIDTH;

    logic [TAG_W-1:0]       pc_tag;
    logic [INDEX_WIDTH-1:0] pc_index;
    logic [BANK_W-1:0]      pc_off;  // word within the line

    lookup_state_e      state_q;
    logic [WAY_NUM-1:0] valid_q [SET_NUM];
    logic [WAY_NUM-1:0] hit_mask;
    logic               hit;
    logic               judge;
    logic [WAY_W-1:0]   victim_q;  // way being refilled
    logic [WORD_W-1:0]  hit_word;

    assign pc_tag   = pc[ADDR_W-1 -: TAG_W];
    assign pc_index = pc[OFFSET_WIDTH +: INDEX_WIDTH];
    assign pc_off   = pc[BYTE_OFF_W +: BANK_W];

    // tag entry is {tag, valid}
    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_mask[w] = valid_q[pc_index][w] & tag_rd[w][0]
                        & (tag_rd[w][TAG_W:1] == pc_tag);
        end
    end

    assign hit = |hit_mask;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (hit_mask[w]) hit_way = WAY_W'(w);
        end
    end

    assign judge    = (state_q == HIT_JUDGE);
    assign hit_word = word_rd[hit_way][pc_off];

    // after a refill the idle cycle hands out the critical word
    assign inst_rdata = (judge && hit) ? hit_word : saved_word;
    assign stall      = (state_q == LOAD_MEMORY) | (judge & inst_en & ~hit);
    assign miss_req   = (state_q == LOAD_MEMORY) & ~fill_done;
    assign line_addr  = {pc[ADDR_W-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign word_off   = pc_off;

    // while refilling, touch_way also names the way the top writes
    assign touch     = (judge & inst_en & hit) | fill_done;
    assign touch_way = (state_q == LOAD_MEMORY) ? victim_q : hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:        if (!fetch_stall) state_q <= HIT_JUDGE;
                HIT_JUDGE:   if (inst_en && !hit) state_q <= LOAD_MEMORY;
                LOAD_MEMORY: if (fill_done) state_q <= IDLE;
                default:     state_q <= IDLE;
            endcase
        end
    end

    // the arrays power up with junk, so valid lives here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_NUM; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_done) begin
            valid_q[pc_index][victim_q] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (judge && inst_en && !hit) begin
            victim_q <= victim_way;  // plru may move before the fill ends
        end
    end

endmodule

//--- icache_refill.sv
`timescale 1ns/10ps

module icache_refill
    import icache_pkg::*;
#(
    parameter  int OFFSET_WIDTH = 5,
    localparam int BANK_W       = OFFSET_WIDTH - BYTE_OFF_W,
    localparam int BANK_NUM     = 1 << BANK_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                miss_req,
    input  logic [ADDR_W-1:0]   line_addr,
    input  logic [BANK_W-1:0]   word_off,
    output axi_ar_t             ar,
    output logic                arvalid,
    input  logic                arready,
    input  axi_r_t              r,
    input  logic                rvalid,
    output logic                rready,
    output logic [BANK_NUM-1:0] bank_we,
    output logic [WORD_W-1:0]   fill_data,
    output logic                fill_done,
    output logic [WORD_W-1:0]   saved_word
);

    refill_state_e     state_q;
    logic [BANK_W-1:0] beat_cnt;  // bank of the next beat
    axi_ar_t           ar_q;
    logic              beat;

    assign arvalid   = (state_q == R_ADDR);
    assign rready    = (state_q == R_DATA);
    assign ar        = ar_q;
    assign beat      = rready & rvalid;
    assign fill_data = r.data;
    assign fill_done = beat & r.last;

    // one bank per beat, in burst order
    always_comb begin
        bank_we           = '0;
        bank_we[beat_cnt] = beat;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= R_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state_q)
                R_IDLE: if (miss_req) state_q <= R_ADDR;
                R_ADDR: if (arready) state_q <= R_DATA;
                R_DATA: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last) begin
                            state_q  <= R_IDLE;
                            beat_cnt <= '0;
                        end
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    // request payload frozen for the whole burst
    always_ff @(posedge clk) begin
        if (state_q == R_IDLE && miss_req) begin
            ar_q.addr <= {line_addr[ADDR_W-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
            ar_q.len  <= 8'(BANK_NUM - 1);
        end
        if (beat && beat_cnt == word_off) begin
            saved_word <= r.data;  // critical word for the stalled fetch
        end
    end

endmodule

//--- icache_plru.sv
`timescale 1ns/10ps

module icache_plru
    import icache_pkg::*;
#(
    parameter int INDEX_WIDTH = 7
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic                   touch,
    input  logic [WAY_W-1:0]       touch_way,
    output logic [WAY_W-1:0]       victim_way
);

    localparam int SET_NUM = 1 << INDEX_WIDTH;

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [WAY_NUM-2:0] lru_q [SET_NUM];
    logic [WAY_NUM-2:0] cur;

    assign cur = lru_q[index];

    // follow the tree down to the least recently used leaf
    always_comb begin
        victim_way[1] = cur[0];
        victim_way[0] = cur[0] ? cur[2] : cur[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_NUM; s++) begin
                lru_q[s] <= '0;
            end
        end else if (touch) begin
            lru_q[index][0] <= ~touch_way[1];  // root away from touched half
            if (touch_way[1]) begin
                lru_q[index][2] <= ~touch_way[0];
            end else begin
                lru_q[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

//--- icache_ram.sv
`timescale 1ns/10ps

module icache_ram #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 7
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [DEPTH_LOG2-1:0] waddr,
    input  logic [WIDTH-1:0]      wdata,
    input  logic                  re,
    input  logic [DEPTH_LOG2-1:0] raddr,
    output logic [WIDTH-1:0]      rdata
);

    logic [WIDTH-1:0] mem [1 << DEPTH_LOG2];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds last word while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];  // old data on same-address write
        end
    end

endmodule

//--- icache_pkg.sv
package icache_pkg;

    // fetch side widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // byte offset inside one instruction word
    localparam int BYTE_OFF_W = 2;

    // associativity, the tree lru below is built for exactly four
    localparam int WAY_NUM = 4;
    localparam int WAY_W   = 2;

    // lookup fsm
    typedef enum logic [1:0] {
        IDLE        = 2'b00,  // waiting for the stage to release the arrays
        HIT_JUDGE   = 2'b01,  // tags valid for pc, compare this cycle
        LOAD_MEMORY = 2'b11   // line refill in flight
    } lookup_state_e;

    // refill fsm
    typedef enum logic [1:0] {
        R_IDLE = 2'b00,
        R_ADDR = 2'b01,  // ar held until accepted
        R_DATA = 2'b10   // collecting r beats up to last
    } refill_state_e;

    // ar channel payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr;  // line aligned
        logic [7:0]        len;   // beats minus one
    } axi_ar_t;

    // r channel payload
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } axi_r_t;

endpackage
